//--- cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Data path and instruction width in bits
`define CPU_XLEN 32

// Architectural registers, r0 is hardwired to zero
`define CPU_NUM_REGS 32

// Unified instruction and data memory, in words
`define CPU_MEM_DEPTH 1024

`endif

//--- cpu_isa_pkg.sv
`default_nettype none

`include "cpu_settings.svh"

package cpu_isa_pkg;

   typedef logic [`CPU_XLEN-1:0] word_t;
   typedef logic [$clog2(`CPU_NUM_REGS)-1:0] reg_idx_t;
   // Word address, taken from the low bits of a register value
   typedef logic [$clog2(`CPU_MEM_DEPTH)-1:0] mem_addr_t;
   typedef logic [15:0] imm16_t;

   // Opcode in bits 31:27, codes not listed run as NOP
   typedef enum logic [4:0] {
      NOP      = 5'd0,
      LOAD_IMM = 5'd1,
      LOAD_MEM = 5'd2,
      STORE    = 5'd3,
      ALU      = 5'd4,
      JUMP_NZ  = 5'd5,
      HALT     = 5'd6
   } instr_type_e;

   // ALU function in bits 4:0
   typedef enum logic [4:0] {
      ALU_ADD = 5'd0,
      ALU_SUB = 5'd1,
      ALU_AND = 5'd2,
      ALU_OR  = 5'd3,
      ALU_XOR = 5'd4,
      ALU_SLT = 5'd5
   } alu_op_e;

   // Field layout: rd 26:22, ra 21:17, rb 16:12
   // imm16 sits in 15:0 and overlaps rb, only LOAD_IMM uses it
   function automatic instr_type_e instr_type(word_t instr);
      return instr_type_e'(instr[31:27]);
   endfunction

   function automatic reg_idx_t instr_rd(word_t instr);
      return instr[26:22];
   endfunction

   function automatic reg_idx_t instr_ra(word_t instr);
      return instr[21:17];
   endfunction

   function automatic reg_idx_t instr_rb(word_t instr);
      return instr[16:12];
   endfunction

   // Zero-extended immediate
   function automatic word_t instr_imm(word_t instr);
      imm16_t imm;
      imm = instr[15:0];
      return word_t'(imm);
   endfunction

   function automatic alu_op_e instr_alu_op(word_t instr);
      return alu_op_e'(instr[4:0]);
   endfunction

endpackage

`default_nettype wire

//--- cpu_pipe_pkg.sv
`default_nettype none

package cpu_pipe_pkg;

   import cpu_isa_pkg::*;

   // Issue to execute, operands already read
   typedef struct packed {
      logic        valid;
      instr_type_e itype;
      reg_idx_t    rd;
      word_t       ra_val;
      word_t       rb_val;
      word_t       imm;
      alu_op_e     alu_op;
      logic        writes_rd;
   } decoded_t;

   // Execute to memory stage
   typedef struct packed {
      logic        valid;
      instr_type_e itype;
      reg_idx_t    rd;
      word_t       result;
      mem_addr_t   mem_addr;
      word_t       store_data;
      logic        writes_rd;
   } exec_t;

   // Memory stage and writeback, also the retire trace
   typedef struct packed {
      logic     valid;
      reg_idx_t rd;
      word_t    data;
      logic     writes_rd;
   } retire_t;

endpackage

`default_nettype wire

//--- hazard_detector.sv
`timescale 1ns/100ps
`default_nettype none

module hazard_detector import cpu_isa_pkg::*, cpu_pipe_pkg::*; (
   input  word_t    issue_instr,
   input  logic     issue_valid,
   input  decoded_t dec_rec,
   input  exec_t    exe_rec,
   input  retire_t  mem_rec,
   output logic     stall
);

   instr_type_e itype;
   reg_idx_t    src_a;
   reg_idx_t    src_b;
   logic        uses_a;
   logic        uses_b;
   logic        hit_a;
   logic        hit_b;

   // True when src is the pending destination of one in-flight record
   function automatic logic pending(reg_idx_t src, logic valid, logic writes, reg_idx_t rd);
      return (src != '0) && valid && writes && (rd == src);
   endfunction

   assign itype = instr_type(issue_instr);
   assign src_a = instr_ra(issue_instr);
   assign src_b = instr_rb(issue_instr);

   // LOAD_IMM has its immediate where rb would be, so it reads nothing
   assign uses_a = itype inside {LOAD_MEM, STORE, ALU, JUMP_NZ};
   assign uses_b = itype inside {STORE, ALU, JUMP_NZ};

   assign hit_a = uses_a && (pending(src_a, dec_rec.valid, dec_rec.writes_rd, dec_rec.rd) ||
                             pending(src_a, exe_rec.valid, exe_rec.writes_rd, exe_rec.rd) ||
                             pending(src_a, mem_rec.valid, mem_rec.writes_rd, mem_rec.rd));

   assign hit_b = uses_b && (pending(src_b, dec_rec.valid, dec_rec.writes_rd, dec_rec.rd) ||
                             pending(src_b, exe_rec.valid, exe_rec.writes_rd, exe_rec.rd) ||
                             pending(src_b, mem_rec.valid, mem_rec.writes_rd, mem_rec.rd));

   assign stall = issue_valid && (hit_a || hit_b);

endmodule

`default_nettype wire

//--- fetch_unit.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_unit import cpu_isa_pkg::*; (
   input  logic      clk,
   input  logic      rst,
   input  logic      run,
   input  logic      stall,
   input  logic      jump_taken,
   input  word_t     jump_target,
   input  logic      halt_seen,
   input  word_t     imem_data,
   output mem_addr_t imem_addr,
   output word_t     issue_instr,
   output logic      issue_valid,
   output word_t     pc_value
);

   word_t pc;
   word_t hold_q;
   logic  hold_sel;
   logic  frozen;

   assign imem_addr = pc[$bits(mem_addr_t)-1:0];
   assign pc_value  = pc;

   // Memory output is the issue word, except while a stalled word is replayed
   assign issue_instr = hold_sel ? hold_q : imem_data;

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         pc          <= '0;
         issue_valid <= 1'b0;
         hold_sel    <= 1'b0;
         frozen      <= 1'b0;
      end else if (jump_taken) begin
         // Squash, the word read this edge is from the old path
         pc          <= jump_target;
         issue_valid <= 1'b0;
         hold_sel    <= 1'b0;
         frozen      <= 1'b0;
      end else if (halt_seen) begin
         issue_valid <= 1'b0;
         hold_sel    <= 1'b0;
         frozen      <= 1'b1;
      end else if (stall) begin
         hold_sel <= 1'b1;
      end else if (run && !frozen) begin
         pc          <= pc + word_t'(1);
         issue_valid <= 1'b1;
         hold_sel    <= 1'b0;
      end else begin
         issue_valid <= 1'b0;
         hold_sel    <= 1'b0;
      end
   end

   // Copy of the stalled word, memory has moved on by then
   always_ff @(posedge clk) begin
      if (stall) begin
         hold_q <= issue_instr;
      end
   end

   pc_hold_on_stall: assert property (@(posedge clk) disable iff (!rst)
      stall && !jump_taken |=> $stable(pc))
      else $error("PC changed during a stall");

endmodule

`default_nettype wire

//--- decode_stage.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_settings.svh"

module decode_stage import cpu_isa_pkg::*, cpu_pipe_pkg::*; (
   input  logic     clk,
   input  logic     rst,
   input  word_t    issue_instr,
   input  logic     issue_valid,
   input  logic     stall,
   input  logic     squash,
   input  retire_t  wb_rec,
   output decoded_t dec_rec,
   output logic     halt_seen
);

   word_t       regs [`CPU_NUM_REGS];
   instr_type_e itype;
   reg_idx_t    ra;
   reg_idx_t    rb;
   word_t       ra_val;
   word_t       rb_val;
   logic        advance;
   logic        known_type;
   logic        wb_write;
   decoded_t    dec_next;

   assign itype = instr_type(issue_instr);
   assign ra    = instr_ra(issue_instr);
   assign rb    = instr_rb(issue_instr);

   // Instruction leaves issue this edge
   assign advance   = issue_valid && !stall && !squash;
   assign halt_seen = advance && (itype == HALT);

   always_comb begin
      case (itype)
         LOAD_IMM, LOAD_MEM, STORE, ALU, JUMP_NZ, HALT: known_type = 1'b1;
         default: known_type = 1'b0;
      endcase
   end

   // Register file, writeback is visible to reads in the same cycle
   assign wb_write = wb_rec.valid && wb_rec.writes_rd && (wb_rec.rd != '0);

   assign ra_val = (ra == '0) ? '0 :
                   (wb_write && wb_rec.rd == ra) ? wb_rec.data : regs[ra];
   assign rb_val = (rb == '0) ? '0 :
                   (wb_write && wb_rec.rd == rb) ? wb_rec.data : regs[rb];

   always_ff @(posedge clk) begin
      if (wb_write) begin
         regs[wb_rec.rd] <= wb_rec.data;
      end
   end

   // NOP and undefined codes go down the pipe as bubbles
   always_comb begin
      dec_next.valid     = advance && known_type;
      dec_next.itype     = itype;
      dec_next.rd        = instr_rd(issue_instr);
      dec_next.ra_val    = ra_val;
      dec_next.rb_val    = rb_val;
      dec_next.imm       = instr_imm(issue_instr);
      dec_next.alu_op    = instr_alu_op(issue_instr);
      dec_next.writes_rd = advance && (itype inside {LOAD_IMM, LOAD_MEM, ALU});
   end

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         dec_rec <= '0;
      end else begin
         dec_rec <= dec_next;
      end
   end

endmodule

`default_nettype wire

//--- execute_stage.sv
`timescale 1ns/100ps
`default_nettype none

module execute_stage import cpu_isa_pkg::*, cpu_pipe_pkg::*; (
   input  logic     clk,
   input  logic     rst,
   input  decoded_t dec_rec,
   output exec_t    exe_rec,
   output logic     jump_taken,
   output word_t    jump_target
);

   word_t alu_res;
   word_t result;
   exec_t exe_next;

   always_comb begin
      case (dec_rec.alu_op)
         ALU_ADD: alu_res = dec_rec.ra_val + dec_rec.rb_val;
         ALU_SUB: alu_res = dec_rec.ra_val - dec_rec.rb_val;
         ALU_AND: alu_res = dec_rec.ra_val & dec_rec.rb_val;
         ALU_OR:  alu_res = dec_rec.ra_val | dec_rec.rb_val;
         ALU_XOR: alu_res = dec_rec.ra_val ^ dec_rec.rb_val;
         ALU_SLT: alu_res = word_t'($signed(dec_rec.ra_val) < $signed(dec_rec.rb_val));
         default: alu_res = '0;
      endcase
   end

   // Loads take their data later in the memory stage
   always_comb begin
      case (dec_rec.itype)
         LOAD_IMM: result = dec_rec.imm;
         ALU:      result = alu_res;
         default:  result = '0;
      endcase
   end

   // Branch resolves here, fetch and decode are squashed on a taken jump
   assign jump_taken  = dec_rec.valid && (dec_rec.itype == JUMP_NZ) && (dec_rec.ra_val != '0);
   assign jump_target = dec_rec.rb_val;

   always_comb begin
      exe_next.valid      = dec_rec.valid;
      exe_next.itype      = dec_rec.itype;
      exe_next.rd         = dec_rec.rd;
      exe_next.result     = result;
      exe_next.mem_addr   = dec_rec.ra_val[$bits(mem_addr_t)-1:0];
      exe_next.store_data = dec_rec.rb_val;
      exe_next.writes_rd  = dec_rec.writes_rd;
   end

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         exe_rec <= '0;
      end else begin
         exe_rec <= exe_next;
      end
   end

endmodule

`default_nettype wire

//--- main_memory.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_settings.svh"

module main_memory import cpu_isa_pkg::*; #(
   parameter int depth = `CPU_MEM_DEPTH
) (
   input  logic      clk,
   input  mem_addr_t iaddr,
   output word_t     idata,
   input  mem_addr_t daddr,
   input  word_t     dwdata,
   input  logic      dwe,
   output word_t     drdata
);

   word_t mem [depth];

   // Instruction port, read only
   always_ff @(posedge clk) begin
      idata <= mem[iaddr];
   end

   // Data port returns the old word when read and write share an edge
   always_ff @(posedge clk) begin
      if (dwe) begin
         mem[daddr] <= dwdata;
      end
      drdata <= mem[daddr];
   end

   dwrite_in_range: assert property (@(posedge clk) dwe |-> int'(daddr) < depth)
      else $error("data write past end of memory at %0d", daddr);

endmodule

`default_nettype wire

//--- cpu_pipelined_basic.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_settings.svh"

module cpu_pipelined_basic import cpu_isa_pkg::*, cpu_pipe_pkg::*; (
   input  logic      clk,
   input  logic      rst,
   input  logic      run,
   input  logic      prog_we,
   input  mem_addr_t prog_addr,
   input  word_t     prog_data,
   output word_t     pc_value,
   output logic      wb_valid,
   output reg_idx_t  wb_rd,
   output word_t     wb_data,
   output logic      wb_writes_rd,
   output logic      halted
);

   word_t     issue_instr;
   logic      issue_valid;
   logic      stall;
   logic      jump_taken;
   word_t     jump_target;
   logic      halt_seen;
   mem_addr_t imem_addr;
   word_t     imem_data;
   decoded_t  dec_rec;
   exec_t     exe_rec;
   retire_t   mem_rec;
   retire_t   wb_rec;
   logic      mem_load;
   logic      mem_halt;
   mem_addr_t daddr;
   word_t     dwdata;
   logic      dwe;
   word_t     drdata;

   fetch_unit i_fetch (
      .clk         (clk),
      .rst         (rst),
      .run         (run),
      .stall       (stall),
      .jump_taken  (jump_taken),
      .jump_target (jump_target),
      .halt_seen   (halt_seen),
      .imem_data   (imem_data),
      .imem_addr   (imem_addr),
      .issue_instr (issue_instr),
      .issue_valid (issue_valid),
      .pc_value    (pc_value)
   );

   hazard_detector i_hazard (
      .issue_instr (issue_instr),
      .issue_valid (issue_valid),
      .dec_rec     (dec_rec),
      .exe_rec     (exe_rec),
      .mem_rec     (mem_rec),
      .stall       (stall)
   );

   decode_stage i_decode (
      .clk         (clk),
      .rst         (rst),
      .issue_instr (issue_instr),
      .issue_valid (issue_valid),
      .stall       (stall),
      .squash      (jump_taken),
      .wb_rec      (wb_rec),
      .dec_rec     (dec_rec),
      .halt_seen   (halt_seen)
   );

   execute_stage i_execute (
      .clk         (clk),
      .rst         (rst),
      .dec_rec     (dec_rec),
      .exe_rec     (exe_rec),
      .jump_taken  (jump_taken),
      .jump_target (jump_target)
   );

   // Data port belongs to the program loader while the core is idle
   assign daddr  = run ? exe_rec.mem_addr : prog_addr;
   assign dwdata = run ? exe_rec.store_data : prog_data;
   assign dwe    = run ? (exe_rec.valid && exe_rec.itype == STORE) : prog_we;

   main_memory #(
      .depth (`CPU_MEM_DEPTH)
   ) i_mem (
      .clk    (clk),
      .iaddr  (imem_addr),
      .idata  (imem_data),
      .daddr  (daddr),
      .dwdata (dwdata),
      .dwe    (dwe),
      .drdata (drdata)
   );

   // Memory stage, load data arrives during this cycle
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         mem_rec  <= '0;
         mem_load <= 1'b0;
         mem_halt <= 1'b0;
      end else begin
         mem_rec.valid     <= exe_rec.valid;
         mem_rec.rd        <= exe_rec.rd;
         mem_rec.data      <= exe_rec.result;
         mem_rec.writes_rd <= exe_rec.writes_rd;
         mem_load          <= exe_rec.valid && (exe_rec.itype == LOAD_MEM);
         mem_halt          <= exe_rec.valid && (exe_rec.itype == HALT);
      end
   end

   // Writeback register, also the retire trace
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         wb_rec <= '0;
         halted <= 1'b0;
      end else begin
         wb_rec.valid     <= mem_rec.valid;
         wb_rec.rd        <= mem_rec.rd;
         wb_rec.data      <= mem_load ? drdata : mem_rec.data;
         wb_rec.writes_rd <= mem_rec.writes_rd;
         // Rises together with the HALT retire pulse
         if (mem_rec.valid && mem_halt) begin
            halted <= 1'b1;
         end
      end
   end

   assign wb_valid     = wb_rec.valid;
   assign wb_rd        = wb_rec.rd;
   assign wb_data      = wb_rec.data;
   assign wb_writes_rd = wb_rec.writes_rd;

   // Nothing younger than HALT may reach writeback
   quiet_after_halt: assert property (@(posedge clk) disable iff (!rst)
      halted |=> !wb_valid)
      else $error("instruction retired after HALT");

endmodule

`default_nettype wire

//--- tb_cpu.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_settings.svh"

module tb_cpu import cpu_isa_pkg::*; ();

   localparam int max_retire = 256;
   localparam int halt_timeout = 2000;
   localparam int model_step_limit = 4000;
   localparam int addr_bits = $bits(mem_addr_t);
   localparam mem_addr_t data_base = mem_addr_t'(512);

   logic      clk;
   logic      rst;
   logic      run;
   logic      prog_we;
   mem_addr_t prog_addr;
   word_t     prog_data;
   word_t     pc_value;
   logic      wb_valid;
   reg_idx_t  wb_rd;
   word_t     wb_data;
   logic      wb_writes_rd;
   logic      halted;

   // Memory image of the current program, also the model's start state
   word_t image [`CPU_MEM_DEPTH];
   int    image_len;

   // Expected retire trace, in program order
   reg_idx_t exp_rd [max_retire];
   word_t    exp_data [max_retire];
   logic     exp_wr [max_retire];
   int       exp_count;

   int          retire_idx;
   int          error_count;
   int          programs_run;
   logic        idle_check;
   logic        timed_out;
   logic [31:0] lcg_state;

   cpu_pipelined_basic i_dut (
      .clk          (clk),
      .rst          (rst),
      .run          (run),
      .prog_we      (prog_we),
      .prog_addr    (prog_addr),
      .prog_data    (prog_data),
      .pc_value     (pc_value),
      .wb_valid     (wb_valid),
      .wb_rd        (wb_rd),
      .wb_data      (wb_data),
      .wb_writes_rd (wb_writes_rd),
      .halted       (halted)
   );

   always #10 clk = ~clk;

   // Position in the expected trace
   always @(posedge clk or negedge rst) begin
      if (!rst) begin
         retire_idx <= 0;
      end else if (wb_valid) begin
         retire_idx <= retire_idx + 1;
      end
   end

   idle_quiet: assert property (@(posedge clk) disable iff (!rst)
      idle_check |-> !wb_valid && !halted && pc_value == '0)
      else begin
         error_count = error_count + 1;
         $display("FAILED at %0t: idle core active, wb_valid=%b halted=%b pc=%0h",
                  $time, $sampled(wb_valid), $sampled(halted), $sampled(pc_value));
      end

   retire_expected: assert property (@(posedge clk) disable iff (!rst)
      wb_valid |-> retire_idx < exp_count)
      else begin
         error_count = error_count + 1;
         $display("FAILED at %0t: extra retire #%0d, model has %0d",
                  $time, $sampled(retire_idx), exp_count);
      end

   retire_matches: assert property (@(posedge clk) disable iff (!rst)
      wb_valid && retire_idx < exp_count |->
         wb_writes_rd == exp_wr[retire_idx] &&
         (!exp_wr[retire_idx] ||
          (wb_rd == exp_rd[retire_idx] && wb_data == exp_data[retire_idx])))
      else begin
         error_count = error_count + 1;
         $display("FAILED at %0t: retire #%0d got w=%b r%0d=%h, expected w=%b r%0d=%h",
                  $time, $sampled(retire_idx), $sampled(wb_writes_rd), $sampled(wb_rd),
                  $sampled(wb_data), exp_wr[$sampled(retire_idx)],
                  exp_rd[$sampled(retire_idx)], exp_data[$sampled(retire_idx)]);
      end

   // HALT is the final entry of the trace
   halt_retires_last: assert property (@(posedge clk) disable iff (!rst)
      $rose(halted) |-> wb_valid && retire_idx == exp_count - 1)
      else begin
         error_count = error_count + 1;
         $display("FAILED at %0t: halted rose at retire #%0d, model has %0d",
                  $time, $sampled(retire_idx), exp_count);
      end

   halted_sticky: assert property (@(posedge clk) disable iff (!rst)
      halted |=> halted)
      else begin
         error_count = error_count + 1;
         $display("FAILED at %0t: halted dropped before reset", $time);
      end

   no_retire_after_halt: assert property (@(posedge clk) disable iff (!rst)
      halted |=> !wb_valid)
      else begin
         error_count = error_count + 1;
         $display("FAILED at %0t: wb_valid pulse after HALT", $time);
      end

   function automatic logic [31:0] rand_word();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic word_t enc_load_imm(reg_idx_t rd, logic [15:0] imm);
      return {LOAD_IMM, rd, 6'd0, imm};
   endfunction

   function automatic word_t enc_reg_op(instr_type_e itype, reg_idx_t rd, reg_idx_t ra,
                                        reg_idx_t rb, logic [4:0] low);
      return {itype, rd, ra, rb, 7'd0, low};
   endfunction

   // Unused words decode as NOP, low bits hold the address
   function automatic void clear_image();
      for (int i = 0; i < `CPU_MEM_DEPTH; i++) begin
         image[i] = word_t'(i);
      end
      image_len = 0;
   endfunction

   function automatic void emit(word_t w);
      image[image_len] = w;
      image_len = image_len + 1;
   endfunction

   function automatic void add_expected(logic wr, reg_idx_t rd, word_t data);
      if (exp_count < max_retire) begin
         exp_wr[exp_count]   = wr;
         exp_rd[exp_count]   = rd;
         exp_data[exp_count] = data;
      end
      exp_count = exp_count + 1;
   endfunction

   function automatic word_t alu_ref(logic [4:0] op, word_t a, word_t b);
      case (op)
         5'd0: return a + b;
         5'd1: return a - b;
         5'd2: return a & b;
         5'd3: return a | b;
         5'd4: return a ^ b;
         5'd5: return ($signed(a) < $signed(b)) ? word_t'(1) : word_t'(0);
         default: return '0;
      endcase
   endfunction

   // Sequential ISA model, one instruction per step
   function automatic void run_model();
      word_t    regs [32];
      word_t    mem [`CPU_MEM_DEPTH];
      word_t    pc;
      word_t    w;
      word_t    a;
      word_t    b;
      word_t    res;
      reg_idx_t rd;
      int       steps;
      logic     done;
      exp_count = 0;
      foreach (regs[i]) regs[i] = '0;
      foreach (mem[i]) mem[i] = image[i];
      pc = '0;
      steps = 0;
      done = 1'b0;
      while (!done && steps < model_step_limit) begin
         w  = mem[pc[addr_bits-1:0]];
         rd = w[26:22];
         a  = regs[w[21:17]];
         b  = regs[w[16:12]];
         pc = pc + 1;
         steps = steps + 1;
         case (w[31:27])
            LOAD_IMM, LOAD_MEM, ALU: begin
               if (w[31:27] == LOAD_IMM) begin
                  res = {16'h0, w[15:0]};
               end else if (w[31:27] == LOAD_MEM) begin
                  res = mem[a[addr_bits-1:0]];
               end else begin
                  res = alu_ref(w[4:0], a, b);
               end
               if (rd != '0) regs[rd] = res;
               add_expected(1'b1, rd, res);
            end
            STORE: begin
               mem[a[addr_bits-1:0]] = b;
               add_expected(1'b0, '0, '0);
            end
            JUMP_NZ: begin
               if (a != '0) pc = b;
               add_expected(1'b0, '0, '0);
            end
            HALT: begin
               add_expected(1'b0, '0, '0);
               done = 1'b1;
            end
            default: ;
         endcase
      end
   endfunction

   // Full 32-bit operands come from data words, one negative and one positive
   function automatic void build_alu_program();
      word_t r;
      clear_image();
      image[data_base]     = rand_word() | 32'h8000_0000;
      image[data_base + 1] = rand_word() & 32'h7fff_ffff;
      r = rand_word();
      emit(enc_load_imm(5'd1, 16'(data_base)));
      emit(enc_load_imm(5'd2, 16'(data_base + mem_addr_t'(1))));
      emit(enc_reg_op(LOAD_MEM, 5'd3, 5'd1, 5'd0, 5'd0));
      emit(enc_reg_op(LOAD_MEM, 5'd4, 5'd2, 5'd0, 5'd0));
      emit(enc_load_imm(5'd5, r[15:0]));
      emit(enc_reg_op(ALU, 5'd6, 5'd3, 5'd4, ALU_ADD));
      emit(enc_reg_op(ALU, 5'd7, 5'd3, 5'd4, ALU_SUB));
      emit(enc_reg_op(ALU, 5'd8, 5'd3, 5'd4, ALU_AND));
      emit(enc_reg_op(ALU, 5'd9, 5'd3, 5'd4, ALU_OR));
      emit(enc_reg_op(ALU, 5'd10, 5'd3, 5'd4, ALU_XOR));
      emit(enc_reg_op(ALU, 5'd11, 5'd3, 5'd4, ALU_SLT));
      emit(enc_reg_op(ALU, 5'd12, 5'd4, 5'd3, ALU_SLT));
      emit(enc_reg_op(ALU, 5'd13, 5'd5, 5'd3, ALU_ADD));
      emit(enc_reg_op(HALT, 5'd0, 5'd0, 5'd0, 5'd0));
   endfunction

   // Every instruction reads the one before, STORE then LOAD_MEM back to back
   function automatic void build_dependent_program();
      word_t r1;
      word_t r2;
      clear_image();
      r1 = rand_word();
      r2 = rand_word();
      emit(enc_load_imm(5'd1, r1[15:0]));
      emit(enc_load_imm(5'd2, r2[15:0]));
      emit(enc_reg_op(ALU, 5'd3, 5'd1, 5'd2, ALU_ADD));
      emit(enc_reg_op(ALU, 5'd4, 5'd3, 5'd1, ALU_SUB));
      emit(enc_reg_op(ALU, 5'd5, 5'd4, 5'd3, ALU_XOR));
      emit(enc_load_imm(5'd6, 16'd600));
      emit(enc_reg_op(STORE, 5'd0, 5'd6, 5'd5, 5'd0));
      emit(enc_reg_op(LOAD_MEM, 5'd7, 5'd6, 5'd0, 5'd0));
      emit(enc_reg_op(ALU, 5'd8, 5'd7, 5'd7, ALU_ADD));
      emit(enc_load_imm(5'd9, 16'd601));
      emit(enc_reg_op(STORE, 5'd0, 5'd9, 5'd8, 5'd0));
      emit(enc_reg_op(LOAD_MEM, 5'd10, 5'd9, 5'd0, 5'd0));
      emit(enc_reg_op(ALU, 5'd11, 5'd10, 5'd7, ALU_OR));
      emit(enc_reg_op(HALT, 5'd0, 5'd0, 5'd0, 5'd0));
   endfunction

   function automatic void build_jump_program();
      word_t r;
      int    target;
      int    loop_addr;
      clear_image();
      emit(enc_load_imm(5'd1, 16'd1));
      // Target sits after the jump and two words that must be skipped
      target = image_len + 4;
      emit(enc_load_imm(5'd2, 16'(target)));
      emit(enc_reg_op(JUMP_NZ, 5'd0, 5'd1, 5'd2, 5'd0));
      emit(enc_load_imm(5'd3, 16'hdead));
      emit(enc_load_imm(5'd4, 16'hbeef));
      emit('0);
      emit({5'd25, 27'd0});
      r = rand_word();
      emit(enc_load_imm(5'd5, r[15:0]));
      // r0 is zero, falls through
      emit(enc_reg_op(JUMP_NZ, 5'd0, 5'd0, 5'd2, 5'd0));
      r = rand_word();
      emit(enc_load_imm(5'd6, r[15:0]));
      emit(enc_load_imm(5'd7, 16'd3));
      emit(enc_load_imm(5'd8, 16'd1));
      loop_addr = image_len + 1;
      emit(enc_load_imm(5'd9, 16'(loop_addr)));
      emit(enc_reg_op(ALU, 5'd7, 5'd7, 5'd8, ALU_SUB));
      emit(enc_reg_op(JUMP_NZ, 5'd0, 5'd7, 5'd9, 5'd0));
      emit(enc_reg_op(HALT, 5'd0, 5'd0, 5'd0, 5'd0));
   endfunction

   task automatic apply_reset();
      rst     = 1'b0;
      run     = 1'b0;
      prog_we = 1'b0;
      repeat (10) @(posedge clk);
      #2;
      rst = 1'b1;
   endtask

   task automatic load_image();
      for (int i = 0; i < `CPU_MEM_DEPTH; i++) begin
         @(posedge clk);
         #2;
         prog_we   = 1'b1;
         prog_addr = mem_addr_t'(i);
         prog_data = image[i];
      end
      @(posedge clk);
      #2;
      prog_we = 1'b0;
   endtask

   task automatic run_program(string name);
      int cycles;
      apply_reset();
      run_model();
      idle_check = 1'b1;
      load_image();
      idle_check = 1'b0;
      run = 1'b1;
      cycles = 0;
      while (!halted && cycles < halt_timeout) begin
         @(negedge clk);
         cycles = cycles + 1;
      end
      if (!halted) begin
         error_count = error_count + 1;
         timed_out = 1'b1;
         $display("Timeout: program %s did not halt within %0d cycles", name, halt_timeout);
      end else begin
         // Watch a few cycles for late retires
         repeat (5) @(negedge clk);
         retire_count_ok: assert (retire_idx == exp_count)
            else begin
               error_count = error_count + 1;
               $display("FAILED at %0t: program %s retired %0d, model %0d",
                        $time, name, retire_idx, exp_count);
            end
      end
      programs_run = programs_run + 1;
      @(posedge clk);
      #2;
      run = 1'b0;
   endtask

   initial begin
      clk          = 1'b0;
      rst          = 1'b0;
      run          = 1'b0;
      prog_we      = 1'b0;
      prog_addr    = '0;
      prog_data    = '0;
      idle_check   = 1'b0;
      timed_out    = 1'b0;
      error_count  = 0;
      programs_run = 0;
      exp_count    = 0;
      image_len    = 0;
      lcg_state    = 32'hb839;
      build_alu_program();
      run_program("alu");
      if (!timed_out) begin
         build_dependent_program();
         run_program("dependent");
      end
      if (!timed_out) begin
         build_jump_program();
         run_program("jump");
      end
      $display("Programs run: %0d, errors: %0d", programs_run, error_count);
      if (error_count == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- flist.f
+incdir+.
cpu_isa_pkg.sv
cpu_pipe_pkg.sv
hazard_detector.sv
fetch_unit.sv
decode_stage.sv
execute_stage.sv
main_memory.sv
cpu_pipelined_basic.sv
tb_cpu.sv

//--- Bender.yml
package:
  name: cpu_pipelined_basic

export_include_dirs:
  - .

sources:
  - files:
      - cpu_isa_pkg.sv
      - cpu_pipe_pkg.sv
      - hazard_detector.sv
      - fetch_unit.sv
      - decode_stage.sv
      - execute_stage.sv
      - main_memory.sv
      - cpu_pipelined_basic.sv
  - target: test
    files:
      - tb_cpu.sv
